// File: audio_sat_mixer.sv
/*
 * Stereo audio mixer
 * Adds main and streamed-track audio per channel, clamps to 16 bits signed,
 * one cycle of latency
 */
`timescale 1ns/1ps
`include "snes_loader_macros.svh"

module audio_sat_mixer (
	input  logic                     clk_sys,
	input  logic                     RESET,
	input  snes_loader_pkg::stereo_t main_audio,
	input  snes_loader_pkg::stereo_t track_audio,
	output snes_loader_pkg::stereo_t mixed
);
	logic signed [`AUDIO_W:0] sum_l;
	logic signed [`AUDIO_W:0] sum_r;

	// Top two bits differ only on overflow
	function automatic logic [`AUDIO_W-1:0] sat(input logic [`AUDIO_W:0] s);
		if (s[`AUDIO_W] ^ s[`AUDIO_W-1])
			sat = {s[`AUDIO_W], {(`AUDIO_W-1){~s[`AUDIO_W]}}};
		else
			sat = s[`AUDIO_W-1:0];
	endfunction

	assign sum_l = (`AUDIO_W+1)'(main_audio.l) + (`AUDIO_W+1)'(track_audio.l);
	assign sum_r = (`AUDIO_W+1)'(main_audio.r) + (`AUDIO_W+1)'(track_audio.r);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			mixed <= '0;
		end else begin
			mixed.l <= sat(sum_l);
			mixed.r <= sat(sum_r);
		end
	end

endmodule

// File: cheat_code_assembler.sv
/*
 * Cheat code assembler
 * Collects eight 16-bit code download words into one cheat record
 * and strobes valid once the last word is in
 */
`timescale 1ns/1ps

module cheat_code_assembler (
	input  logic                         clk_sys,
	input  logic                         RESET,
	input  logic                         code_wr,
	input  snes_loader_pkg::dl_word_t    dl,
	output snes_loader_pkg::cheat_code_t cheat
);
	logic        valid_q;
	logic [31:0] flags_q;
	logic [31:0] addr_q;
	logic [31:0] cmp_q;
	logic [31:0] repl_q;

	always_ff @(posedge clk_sys) begin
		if (RESET)
			valid_q <= 1'b0;
		else
			valid_q <= code_wr && dl.addr[3:0] == 4'd14;
	end

	// Low half word first, then high half
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (dl.addr[3:0])
				4'd0:    flags_q[15:0]  <= dl.data;
				4'd2:    flags_q[31:16] <= dl.data;
				4'd4:    addr_q[15:0]   <= dl.data;
				4'd6:    addr_q[31:16]  <= dl.data;
				4'd8:    cmp_q[15:0]    <= dl.data;
				4'd10:   cmp_q[31:16]   <= dl.data;
				4'd12:   repl_q[15:0]   <= dl.data;
				4'd14:   repl_q[31:16]  <= dl.data;
				default: ;
			endcase
		end
	end

	assign cheat = '{valid: valid_q, flags: flags_q, address: addr_q,
		compare: cmp_q, replace: repl_q};

	assert property (@(posedge clk_sys) disable iff (RESET) cheat.valid |=> !cheat.valid);

endmodule

// File: ram_clear_fill.sv
/*
 * Work memory clear
 * Starts on a new cartridge download and walks the whole fill range,
 * one write every other cycle, with selectable WRAM and ARAM patterns
 */
`timescale 1ns/1ps
`include "snes_loader_macros.svh"

module ram_clear_fill (
	input  logic                       clk_sys,
	input  logic                       RESET,
	input  logic                       cart_active,
	input  snes_loader_pkg::fill_sel_t wram_fill_sel,
	input  snes_loader_pkg::fill_sel_t aram_fill_sel,
	output snes_loader_pkg::fill_req_t fill,
	output logic                       clearing
);
	import snes_loader_pkg::*;

	logic                    cart_d;
	logic                    fill_wait;
	logic [`FILL_ADDR_W-1:0] fill_addr;
	logic                    start;
	logic                    fill_we;

	// Power-on patterns of the different console revisions
	function automatic logic [7:0] fill_byte(input fill_sel_t sel,
		input logic [`FILL_ADDR_W-1:0] a);
		case (sel)
			FILL_9966: fill_byte = (a[8] ^ a[2]) ? 8'h66 : 8'h99;
			FILL_00FF: fill_byte = (a[9] ^ a[0]) ? 8'hFF : 8'h00;
			FILL_55:   fill_byte = 8'h55;
			FILL_FF:   fill_byte = 8'hFF;
		endcase
	endfunction

	assign start   = cart_active & ~cart_d;
	assign fill_we = clearing & ~fill_wait;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_d    <= 1'b0;
			clearing  <= 1'b0;
			fill_wait <= 1'b0;
			fill_addr <= '0;
		end else begin
			cart_d <= cart_active;
			if (clearing) begin
				fill_wait <= ~fill_wait;
				if (fill_wait)
					fill_addr <= fill_addr + 1'b1;
				// Done with the write to the top address
				if (fill_we && &fill_addr)
					clearing <= 1'b0;
			end else begin
				fill_wait <= 1'b0;
				fill_addr <= '0;
			end
			if (start)
				clearing <= 1'b1;
		end
	end

	always_comb begin
		fill.we        = fill_we;
		fill.addr      = fill_addr;
		fill.wram_data = fill_byte(wram_fill_sel, fill_addr);
		fill.aram_data = fill_byte(aram_fill_sel, fill_addr);
	end

	assert property (@(posedge clk_sys) disable iff (RESET) fill.we |=> !fill.we);

endmodule

// File: rom_header_detect.sv
/*
 * ROM header detection
 * Watches the cartridge download and derives ROM type, ROM and RAM
 * address masks and the video region
 */
`timescale 1ns/1ps
`include "snes_loader_macros.svh"

module rom_header_detect (
	input  logic                         clk_sys,
	input  logic                         RESET,
	input  logic                         cart_active,
	input  snes_loader_pkg::dl_word_t    dl,
	input  snes_loader_pkg::header_mode_t header_mode,
	input  snes_loader_pkg::region_sel_t region_sel,
	output snes_loader_pkg::cart_info_t  cart_info
);
	import snes_loader_pkg::*;

	logic [3:0]            rom_size;
	logic [3:0]            ram_size;
	logic                  rom_region;
	logic                  forced_mode;
	logic [`DL_ADDR_W-1:0] size_addr;

	// Size byte location for the forced header modes
	always_comb begin
		forced_mode = 1'b1;
		size_addr = '0;
		case (header_mode)
			HM_LOROM:   size_addr = `DL_ADDR_W'(`LOROM_SIZE_ADDR + `HDR_OFFSET);
			HM_HIROM:   size_addr = `DL_ADDR_W'(`HIROM_SIZE_ADDR + `HDR_OFFSET);
			HM_EXHIROM: size_addr = `DL_ADDR_W'(`EXHIROM_SIZE_ADDR + `HDR_OFFSET);
			default:    forced_mode = 1'b0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_size   <= '0;
			ram_size   <= '0;
			rom_region <= 1'b0;
			cart_info  <= '0;
		end else if (cart_active) begin
			if (dl.wr) begin
				// Word 0 carries the loader's size byte and mapper type
				if (dl.addr == '0) begin
					rom_size <= 4'hC;
					ram_size <= 4'h0;
					if (header_mode == HM_AUTO && dl.data[7:0] != 8'h00)
						{ram_size, rom_size} <= dl.data[7:0];
					case (header_mode)
						HM_NOHDR, HM_LOROM: cart_info.rom_type <= 8'd0;
						HM_HIROM:           cart_info.rom_type <= 8'd1;
						HM_EXHIROM:         cart_info.rom_type <= 8'd2;
						default:            cart_info.rom_type <= dl.data[15:8];
					endcase
				end

				if (dl.addr == `DL_ADDR_W'(2))
					rom_region <= dl.data[8];

				if (forced_mode && dl.addr == size_addr)
					rom_size <= dl.data[11:8];
				if (forced_mode && dl.addr == size_addr + 2'd2)
					ram_size <= dl.data[3:0];

				// Masks use the sizes held before this write
				cart_info.rom_mask <= (`MASK_W'(1024) << rom_size) - 1'b1;
				cart_info.ram_mask <= (ram_size != 4'h0) ?
					(`MASK_W'(1024) << ram_size) - 1'b1 : '0;
			end
		end else begin
			cart_info.pal <= (region_sel == REG_AUTO) ? rom_region : region_sel[1];
		end
	end

	// RAM mask always a contiguous low run of ones
	assert property (@(posedge clk_sys) disable iff (RESET)
		((cart_info.ram_mask + 1'b1) & cart_info.ram_mask) == '0);

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build the loader testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
	--top-module tb_snes_loader -o tb_snes_loader > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_snes_loader > sim.log 2>&1
cat sim.log
grep -q "TEST PASSED" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// File: snes_loader_macros.svh
/*
 * Cartridge loader constants
 * Widths, copier header offsets, header size-byte locations and fill size
 */
`ifndef SNES_LOADER_MACROS_SVH
`define SNES_LOADER_MACROS_SVH

// ========================================
// Download bus
// ========================================
`define DL_ADDR_W 25
`define DL_DATA_W 16

// ========================================
// ROM header
// ========================================
`define MASK_W 24
`define HDR_OFFSET 'h200
// Size byte locations
// RAM size byte sits two above each
`define LOROM_SIZE_ADDR 'h7FD6
`define HIROM_SIZE_ADDR 'hFFD6
`define EXHIROM_SIZE_ADDR 'h40FFD6

// ========================================
// Memory clear, cheats, audio
// ========================================
`define FILL_ADDR_W 18
`define CHEAT_W 129
`define AUDIO_W 16

`endif

// File: snes_loader_pkg.sv
/*
 * Shared types of the cartridge loader
 * Download words, setting encodings, cartridge info, fill requests,
 * cheat records and stereo samples
 */
`include "snes_loader_macros.svh"

package snes_loader_pkg;

	localparam int CHEAT_FIELD_W = (`CHEAT_W - 1) / 4;

	typedef struct packed {
		logic                  wr;
		logic [`DL_ADDR_W-1:0] addr;
		logic [`DL_DATA_W-1:0] data;
	} dl_word_t;

	typedef enum logic [1:0] {DL_NONE, DL_CART, DL_SPC, DL_CODE} dl_kind_t;

	typedef enum logic [2:0] {HM_AUTO, HM_NOHDR, HM_LOROM, HM_HIROM, HM_EXHIROM} header_mode_t;

	// High bit doubles as the forced PAL flag
	typedef enum logic [1:0] {REG_AUTO, REG_NTSC, REG_PAL} region_sel_t;

	typedef enum logic [1:0] {FILL_9966, FILL_00FF, FILL_55, FILL_FF} fill_sel_t;

	typedef struct packed {
		logic [7:0]         rom_type;
		logic [`MASK_W-1:0] rom_mask;
		logic [`MASK_W-1:0] ram_mask;
		logic               pal;
	} cart_info_t;

	typedef struct packed {
		logic                    we;
		logic [`FILL_ADDR_W-1:0] addr;
		logic [7:0]              wram_data;
		logic [7:0]              aram_data;
	} fill_req_t;

	// Host cheat file bit layout with valid on top
	typedef struct packed {
		logic                     valid;
		logic [CHEAT_FIELD_W-1:0] flags;
		logic [CHEAT_FIELD_W-1:0] address;
		logic [CHEAT_FIELD_W-1:0] compare;
		logic [CHEAT_FIELD_W-1:0] replace;
	} cheat_code_t;

	typedef struct packed {
		logic signed [`AUDIO_W-1:0] l;
		logic signed [`AUDIO_W-1:0] r;
	} stereo_t;

endpackage

// File: snes_loader_top.sv
/*
 * Cartridge loader and audio glue
 * Decodes the host download index, holds the core during download and
 * memory clear, and ties header detect, clear, cheats and mixer together
 */
`timescale 1ns/1ps

module snes_loader_top (
	input  logic                          clk_sys,
	input  logic                          RESET,
	input  snes_loader_pkg::dl_word_t     dl,
	input  logic                          dl_active,
	input  logic [7:0]                    dl_index,
	input  snes_loader_pkg::header_mode_t header_mode,
	input  snes_loader_pkg::region_sel_t  region_sel,
	input  snes_loader_pkg::fill_sel_t    wram_fill_sel,
	input  snes_loader_pkg::fill_sel_t    aram_fill_sel,
	input  snes_loader_pkg::stereo_t      main_audio,
	input  snes_loader_pkg::stereo_t      track_audio,
	output snes_loader_pkg::cart_info_t   cart_info,
	output snes_loader_pkg::fill_req_t    fill,
	output logic                          clearing,
	output logic                          core_hold,
	output snes_loader_pkg::cheat_code_t  cheat,
	output snes_loader_pkg::stereo_t      mixed
);
	import snes_loader_pkg::*;

	dl_kind_t dl_kind;
	logic     cart_active;
	logic     code_wr;

	// ========================================
	// Download index decode
	// ========================================
	always_comb begin
		if (&dl_index)
			dl_kind = DL_CODE;
		else if (dl_index[5:0] == 6'd0)
			dl_kind = DL_CART;
		else if (dl_index[5:0] == 6'd1)
			dl_kind = DL_SPC;
		else
			dl_kind = DL_NONE;
	end

	assign cart_active = dl_active && dl_kind == DL_CART;
	assign code_wr     = dl_active && dl_kind == DL_CODE && dl.wr;

	// Core stays in reset while the cartridge loads and memory clears
	assign core_hold = RESET | cart_active | clearing;

	// ========================================
	// Blocks
	// ========================================
	rom_header_detect u_rom_header_detect (
		.clk_sys(clk_sys), .RESET(RESET), .cart_active(cart_active), .dl(dl),
		.header_mode(header_mode), .region_sel(region_sel), .cart_info(cart_info)
	);

	ram_clear_fill u_ram_clear_fill (
		.clk_sys(clk_sys), .RESET(RESET), .cart_active(cart_active),
		.wram_fill_sel(wram_fill_sel), .aram_fill_sel(aram_fill_sel),
		.fill(fill), .clearing(clearing)
	);

	cheat_code_assembler u_cheat_code_assembler (
		.clk_sys(clk_sys), .RESET(RESET), .code_wr(code_wr), .dl(dl), .cheat(cheat)
	);

	audio_sat_mixer u_audio_sat_mixer (
		.clk_sys(clk_sys), .RESET(RESET), .main_audio(main_audio),
		.track_audio(track_audio), .mixed(mixed)
	);

endmodule

// File: tb_snes_loader_tasks.svh
/*
 * Directed tests and typed compare tasks of the loader testbench
 * Included into the testbench module body
 */
`ifndef TB_SNES_LOADER_TASKS_SVH
`define TB_SNES_LOADER_TASKS_SVH

// ========================================
// Reporting and compares
// ========================================
task automatic report_mismatch(input string what);
	$display("mismatch at %0t: %s", $time, what);
	error_count++;
endtask

task automatic report_failure(input string what);
	$display("failure at %0t: %s", $time, what);
	error_count++;
endtask

task automatic finish_test(input string name, input int errs_before);
	tests_run++;
	if (error_count == errs_before) begin
		$display("%s: pass", name);
	end else begin
		$display("%s: fail, %0d errors", name, error_count - errs_before);
		tests_failed++;
	end
endtask

task automatic cmp_cart_info(input cart_info_t got, input cart_info_t exp, input string what);
	if (got !== exp)
		report_mismatch($sformatf("%s got type %h rom %h ram %h pal %b, expected %h %h %h %b",
			what, got.rom_type, got.rom_mask, got.ram_mask, got.pal,
			exp.rom_type, exp.rom_mask, exp.ram_mask, exp.pal));
endtask

task automatic cmp_fill(input fill_req_t got, input fill_req_t exp, input string what);
	if (got !== exp)
		report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
endtask

task automatic cmp_cheat(input cheat_code_t got, input cheat_code_t exp, input string what);
	if (got !== exp)
		report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
endtask

task automatic cmp_stereo(input stereo_t got, input stereo_t exp, input string what);
	if (got !== exp)
		report_mismatch($sformatf("%s got l %0d r %0d expected l %0d r %0d", what,
			$signed(got.l), $signed(got.r), $signed(exp.l), $signed(exp.r)));
endtask

// ========================================
// Reference rules
// ========================================
// 1024 * 2^size - 1 with a zero RAM size meaning no RAM
function automatic logic [`MASK_W-1:0] size_mask(input int size, input bit zero_is_none);
	if (zero_is_none && size == 0)
		return '0;
	return `MASK_W'((1 << (10 + size)) - 1);
endfunction

function automatic logic [7:0] pattern_byte(input fill_sel_t sel, input logic [17:0] a);
	case (sel)
		FILL_9966: return (a[8] != a[2]) ? 8'h66 : 8'h99;
		FILL_00FF: return (a[9] != a[0]) ? 8'hFF : 8'h00;
		FILL_55:   return 8'h55;
		default:   return 8'hFF;
	endcase
endfunction

function automatic logic [15:0] clamp16(input int s);
	if (s > 32767)
		return 16'h7FFF;
	if (s < -32768)
		return 16'h8000;
	return 16'(s);
endfunction

// ========================================
// Drivers
// ========================================
task automatic send_word(input logic [`DL_ADDR_W-1:0] addr, input logic [15:0] data);
	@(negedge clk_sys);
	dl = '{wr: 1'b1, addr: addr, data: data};
	@(negedge clk_sys);
	dl.wr = 1'b0;
endtask

task automatic wait_clear_done();
	int cycles;
	cycles = 0;
	while (clearing && cycles < CLEAR_CYCLES + 100) begin
		@(negedge clk_sys);
		cycles++;
	end
	if (clearing)
		report_failure("memory clear did not finish");
endtask

// ========================================
// Directed tests
// ========================================
task automatic test_reset_state();
	int errs_before;
	errs_before = error_count;
	if (fill.we !== 1'b0 || clearing !== 1'b0 || cheat.valid !== 1'b0)
		report_mismatch("fill write, clearing or cheat valid active in reset");
	if (cart_info.pal !== 1'b0 || core_hold !== 1'b1)
		report_mismatch("pal or core_hold wrong in reset");
	finish_test("reset_state", errs_before);
endtask

task automatic test_auto_header();
	int         errs_before;
	cart_info_t exp;
	errs_before = error_count;
	@(negedge clk_sys);
	header_mode = HM_AUTO;
	region_sel  = REG_AUTO;
	dl_index    = 8'h00;
	dl_active   = 1'b1;
	send_word(0, 16'h210B);
	send_word(2, 16'h0100);
	send_word(4, 16'($urandom));
	send_word(6, 16'($urandom));
	@(negedge clk_sys);
	dl_active = 1'b0;
	repeat (2) @(negedge clk_sys);
	exp = '{rom_type: 8'h21, rom_mask: size_mask(11, 0), ram_mask: '0, pal: 1'b1};
	cmp_cart_info(cart_info, exp, "auto header");
	wait_clear_done();
	finish_test("auto_header", errs_before);
endtask

task automatic test_forced_hirom();
	int         errs_before;
	cart_info_t exp;
	errs_before = error_count;
	@(negedge clk_sys);
	header_mode = HM_HIROM;
	dl_active   = 1'b1;
	send_word(0, 16'h55AA);
	send_word(`HIROM_SIZE_ADDR + `HDR_OFFSET, 16'h0A00);
	send_word(`HIROM_SIZE_ADDR + `HDR_OFFSET + 2, 16'h0003);
	send_word(`HIROM_SIZE_ADDR + `HDR_OFFSET + 4, 16'($urandom));
	@(negedge clk_sys);
	dl_active  = 1'b0;
	region_sel = REG_NTSC;
	repeat (2) @(negedge clk_sys);
	exp = '{rom_type: 8'h01, rom_mask: size_mask(10, 0), ram_mask: size_mask(3, 1), pal: 1'b0};
	cmp_cart_info(cart_info, exp, "forced hirom");
	wait_clear_done();
	finish_test("forced_hirom", errs_before);
endtask

task automatic test_memory_clear();
	int                      errs_before;
	int                      writes;
	int                      cycles;
	bit                      hold_ok;
	fill_sel_t               wsel;
	fill_sel_t               asel;
	fill_req_t               exp;
	logic [`FILL_ADDR_W-1:0] exp_addr;
	errs_before = error_count;
	wsel = fill_sel_t'($urandom_range(3));
	asel = fill_sel_t'($urandom_range(3));
	for (int i = 0; i < FILL_DEPTH; i++)
		seen[i] = 1'b0;
	@(negedge clk_sys);
	wram_fill_sel = wsel;
	aram_fill_sel = asel;
	dl_index      = 8'h00;
	dl_active     = 1'b1;
	@(negedge clk_sys);
	if (!clearing)
		report_failure("clearing did not rise after the download started");
	dl_active = 1'b0;
	writes    = 0;
	cycles    = 0;
	hold_ok   = 1'b1;
	while (clearing && cycles < CLEAR_CYCLES + 100) begin
		hold_ok &= core_hold;
		if (fill.we) begin
			if (seen[fill.addr])
				report_failure($sformatf("fill address %h written twice", fill.addr));
			seen[fill.addr] = 1'b1;
			// Addresses step up from zero, one per write
			exp_addr = `FILL_ADDR_W'(writes);
			exp = '{we: 1'b1, addr: exp_addr, wram_data: pattern_byte(wsel, exp_addr),
				aram_data: pattern_byte(asel, exp_addr)};
			cmp_fill(fill, exp, "fill write");
			writes++;
		end
		@(negedge clk_sys);
		cycles++;
	end
	if (clearing)
		report_failure("memory clear did not finish");
	if (!hold_ok)
		report_failure("core_hold dropped during the memory clear");
	if (writes != FILL_DEPTH)
		report_mismatch($sformatf("%0d fill writes, expected %0d", writes, FILL_DEPTH));
	finish_test("memory_clear", errs_before);
endtask

task automatic test_cheat_record();
	int          errs_before;
	int          pulses_before;
	logic [15:0] words [8];
	cheat_code_t exp;
	errs_before = error_count;
	for (int i = 0; i < 8; i++)
		words[i] = 16'($urandom);
	@(negedge clk_sys);
	dl_index      = 8'hFF;
	dl_active     = 1'b1;
	pulses_before = valid_pulses;
	for (int i = 0; i < 8; i++)
		send_word(`DL_ADDR_W'('h40 + 2 * i), words[i]);
	@(negedge clk_sys);
	dl_active = 1'b0;
	repeat (2) @(negedge clk_sys);
	if (valid_pulses != pulses_before + 1)
		report_mismatch($sformatf("%0d valid pulses, expected 1", valid_pulses - pulses_before));
	exp = '{valid: 1'b1, flags: {words[1], words[0]}, address: {words[3], words[2]},
		compare: {words[5], words[4]}, replace: {words[7], words[6]}};
	cmp_cheat(last_cheat, exp, "cheat record");
	// Same words under the cartridge index
	pulses_before = valid_pulses;
	dl_index      = 8'h00;
	dl_active     = 1'b1;
	for (int i = 0; i < 8; i++)
		send_word(`DL_ADDR_W'(2 * i), words[i]);
	@(negedge clk_sys);
	dl_active = 1'b0;
	repeat (2) @(negedge clk_sys);
	if (valid_pulses != pulses_before)
		report_failure("cheat valid pulsed during a cartridge download");
	finish_test("cheat_record", errs_before);
endtask

task automatic test_audio_mix();
	int      errs_before;
	stereo_t a;
	stereo_t b;
	stereo_t exp;
	errs_before = error_count;
	for (int i = 0; i <= AUDIO_SAMPLES; i++) begin
		@(negedge clk_sys);
		if (i > 0)
			cmp_stereo(mixed, exp, $sformatf("audio sample %0d", i - 1));
		if (i == AUDIO_SAMPLES)
			break;
		a = stereo_t'($urandom);
		b = stereo_t'($urandom);
		case (i % 4)
			// Sums straddling both limits
			0: begin
				a.l = 16'(32767 - $urandom_range(255));
				b.l = 16'($urandom_range(511));
				a.r = 16'(32768 + $urandom_range(255));
				b.r = 16'(-int'($urandom_range(511)));
			end
			1: begin
				a.l = 16'h7FFF;
				b.l = 16'h7FFF;
				a.r = 16'h8000;
				b.r = 16'h8000;
			end
			default: ;
		endcase
		main_audio  = a;
		track_audio = b;
		exp.l = clamp16(int'($signed(a.l)) + int'($signed(b.l)));
		exp.r = clamp16(int'($signed(a.r)) + int'($signed(b.r)));
	end
	main_audio  = '0;
	track_audio = '0;
	finish_test("audio_mix", errs_before);
endtask

`endif

// File: tb_snes_loader.sv
/*
 * Testbench for the cartridge loader and audio glue
 * Clock, reset, watchdog, directed test sequence and the final report
 */
`timescale 1ns/1ps
`include "snes_loader_macros.svh"

module tb_snes_loader;
	import snes_loader_pkg::*;

	localparam int FILL_DEPTH      = 1 << `FILL_ADDR_W;
	// One write every other cycle
	localparam int CLEAR_CYCLES    = 2 * FILL_DEPTH;
	localparam int WATCHDOG_CYCLES = 3 * CLEAR_CYCLES + 20000;
	localparam int AUDIO_SAMPLES   = 200;

	logic         clk_sys;
	logic         RESET;
	dl_word_t     dl;
	logic         dl_active;
	logic [7:0]   dl_index;
	header_mode_t header_mode;
	region_sel_t  region_sel;
	fill_sel_t    wram_fill_sel;
	fill_sel_t    aram_fill_sel;
	stereo_t      main_audio;
	stereo_t      track_audio;
	cart_info_t   cart_info;
	fill_req_t    fill;
	logic         clearing;
	logic         core_hold;
	cheat_code_t  cheat;
	stereo_t      mixed;

	int           error_count;
	int           tests_run;
	int           tests_failed;
	int           valid_pulses;
	cheat_code_t  last_cheat;
	bit           seen [FILL_DEPTH];

	snes_loader_top dut (.*);

	always #4 clk_sys = ~clk_sys;

	// Count cheat valid pulses on the falling edge
	always @(negedge clk_sys) begin
		if (cheat.valid) begin
			valid_pulses++;
			last_cheat = cheat;
		end
	end

	`include "tb_snes_loader_tasks.svh"

	// ========================================
	// Watchdog
	// ========================================
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("watchdog expired after %0d cycles, tests did not complete", WATCHDOG_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

	// ========================================
	// Test sequence
	// ========================================
	initial begin
		void'($urandom(32'ha8aa_d4d7));
		clk_sys       = 1'b0;
		RESET         = 1'b1;
		dl            = '0;
		dl_active     = 1'b0;
		dl_index      = 8'h00;
		header_mode   = HM_AUTO;
		region_sel    = REG_AUTO;
		wram_fill_sel = FILL_9966;
		aram_fill_sel = FILL_9966;
		main_audio    = '0;
		track_audio   = '0;
		repeat (10) @(posedge clk_sys);
		@(negedge clk_sys);
		test_reset_state();
		RESET = 1'b0;
		test_auto_header();
		test_forced_hirom();
		test_memory_clear();
		test_cheat_record();
		test_audio_mix();
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
		if (error_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: verilog.f
+incdir+.
snes_loader_pkg.sv
rom_header_detect.sv
ram_clear_fill.sv
cheat_code_assembler.sv
audio_sat_mixer.sv
snes_loader_top.sv
tb_snes_loader.sv
